//--- include/sv32_macros.svh
// Sv32 field widths, memory size and reset pc, included by the package and the RTL
`ifndef SV32_MACROS_SVH
`define SV32_MACROS_SVH

// virtual and physical addresses share one width here
`define SV32_ADDR_WIDTH 32

// byte offset inside a 4 KiB page
`define SV32_OFFSET_WIDTH 12

// each of vpn1 and vpn0
`define SV32_VPN_WIDTH 10

// ppn as held in satp and in a PTE
`define SV32_PPN_WIDTH 22

// byte offset inside a word, also the PTE size as a shift
`define WORD_OFFSET_WIDTH 2

// 4096 words of instruction memory
`define MEM_INDEX_WIDTH 12

// first fetch address after reset
`define RESET_PC 32'h0000_3000

`endif

//--- logic/fetch_pkg.sv
// shared vector types and enums for the fetch path, imported by the RTL and the bench
`include "sv32_macros.svh"

package fetch_pkg;

    // one byte address, virtual or physical
    typedef logic [`SV32_ADDR_WIDTH-1:0] addr_t;

    // instruction or PTE
    typedef logic [`SV32_ADDR_WIDTH-1:0] word_t;

    typedef logic [`SV32_PPN_WIDTH-1:0] ppn_t;

    typedef logic [`SV32_VPN_WIDTH-1:0] vpn_t;

    typedef logic [`SV32_OFFSET_WIDTH-1:0] offset_t;

    // word index into the instruction memory
    typedef logic [`MEM_INDEX_WIDTH-1:0] mem_index_t;

    // walk level, 2'b11 stands for -1
    typedef logic [1:0] level_t;

    // privilege encoding as in mstatus.mpp
    typedef enum logic [1:0] {
        U_MODE = 2'b00,
        S_MODE = 2'b01,
        M_MODE = 2'b11
    } priv_mode_t;

    typedef enum logic [2:0] {
        IDLE,
        WALK_REQ,
        WALK_WAIT,
        FETCH_REQ,
        FETCH_WAIT,
        DONE
    } walk_state_t;

endpackage

//--- logic/fetch_unit.sv
// pc sequencer that issues one instruction request at a time and buffers the result
`timescale 1ns/1ps
`include "sv32_macros.svh"

module fetch_unit
    import fetch_pkg::*;
(
    input  logic  clk,
    input  logic  rst,

    input  logic  redirect,
    input  addr_t redirect_pc,

    // request to the walker
    output logic  ireq_valid,
    input  logic  ireq_ready,
    output addr_t ireq_addr,

    // response pulse from the walker, always accepted
    input  logic  iresp_valid,
    input  word_t iresp_inst,

    // downstream stream
    output logic  fetch_valid,
    input  logic  fetch_ready,
    output addr_t fetch_pc,
    output word_t fetch_inst
);

    addr_t pc;
    logic  outstanding;
    logic  buf_valid;
    addr_t buf_pc;
    word_t buf_inst;

    logic  req_fire;
    logic  resp_take;
    logic  out_fire;

    // one access at a time, and only into an empty buffer
    assign ireq_valid = !buf_valid && !outstanding;
    assign ireq_addr  = pc;

    assign req_fire  = ireq_valid && ireq_ready;
    // a response with nothing outstanding belongs to a cancelled access
    assign resp_take = iresp_valid && outstanding;
    assign out_fire  = fetch_valid && fetch_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc          <= `RESET_PC;
            outstanding <= 1'b0;
            buf_valid   <= 1'b0;
        end else if (redirect) begin
            // flush, anything still in flight is dropped later
            pc          <= redirect_pc;
            outstanding <= 1'b0;
            buf_valid   <= 1'b0;
        end else begin
            if (req_fire) begin
                outstanding <= 1'b1;
            end
            if (resp_take) begin
                outstanding <= 1'b0;
                buf_valid   <= 1'b1;
                pc          <= pc + addr_t'(4);
            end else if (out_fire) begin
                buf_valid <= 1'b0;
            end
        end
    end

    // pc is still the requested address while the access is outstanding
    always_ff @(posedge clk) begin
        if (resp_take) begin
            buf_pc   <= pc;
            buf_inst <= iresp_inst;
        end
    end

    assign fetch_valid = buf_valid;
    assign fetch_pc    = buf_pc;
    assign fetch_inst  = buf_inst;

endmodule

//--- logic/page_table_walker.sv
// Sv32 two-level page table walker between the fetch unit and memory, bare mode passes through
`timescale 1ns/1ps
`include "sv32_macros.svh"

module page_table_walker
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        kill,

    input  priv_mode_t  priv_mode,
    input  word_t       satp,

    // instruction side
    input  logic        ireq_valid,
    output logic        ireq_ready,
    input  addr_t       ireq_addr,
    output logic        iresp_valid,
    output addr_t       iresp_addr,
    output word_t       iresp_inst,

    // memory side
    output logic        mem_req_valid,
    input  logic        mem_req_ready,
    output addr_t       mem_req_addr,
    input  logic        mem_resp_valid,
    input  word_t       mem_resp_data
);

    walk_state_t state;
    addr_t       req_addr;
    level_t      level;
    addr_t       next_addr;
    word_t       inst_q;

    logic        sv32_en;
    ppn_t        satp_ppn;
    vpn_t        ireq_vpn1;
    vpn_t        vpn0;
    offset_t     page_offset;
    ppn_t        pte_ppn;
    logic        pte_leaf;
    logic        bare_fire;

    // PTE address: ppn * 4096 + vpn * 4
    function automatic addr_t pte_addr(ppn_t ppn, vpn_t vpn);
        logic [`SV32_PPN_WIDTH+`SV32_OFFSET_WIDTH-1:0] full;
        full = {ppn, vpn, {`WORD_OFFSET_WIDTH{1'b0}}};
        return full[`SV32_ADDR_WIDTH-1:0];
    endfunction

    // 34-bit physical address cut to the bus width
    function automatic addr_t phys_addr(ppn_t ppn, offset_t off);
        logic [`SV32_PPN_WIDTH+`SV32_OFFSET_WIDTH-1:0] full;
        full = {ppn, off};
        return full[`SV32_ADDR_WIDTH-1:0];
    endfunction

    // satp.asid is not used, there is no TLB to tag
    assign sv32_en  = (priv_mode != M_MODE) && satp[`SV32_ADDR_WIDTH-1];
    assign satp_ppn = satp[`SV32_PPN_WIDTH-1:0];

    assign ireq_vpn1   = ireq_addr[`SV32_ADDR_WIDTH-1 -: `SV32_VPN_WIDTH];
    assign vpn0        = req_addr[`SV32_OFFSET_WIDTH +: `SV32_VPN_WIDTH];
    assign page_offset = req_addr[`SV32_OFFSET_WIDTH-1:0];

    // only R and X are looked at, V/A/D/U are ignored
    assign pte_ppn  = mem_resp_data[`SV32_ADDR_WIDTH-1 -: `SV32_PPN_WIDTH];
    assign pte_leaf = mem_resp_data[1] || mem_resp_data[3];

    assign bare_fire = ireq_valid && mem_req_ready;

    // mode mux, kill keeps a cancelled request off the memory
    always_comb begin
        if (sv32_en) begin
            ireq_ready    = (state == IDLE);
            mem_req_valid = !kill && ((state == WALK_REQ) || (state == FETCH_REQ));
            mem_req_addr  = next_addr;
            iresp_valid   = (state == DONE);
            iresp_inst    = inst_q;
        end else begin
            ireq_ready    = mem_req_ready;
            mem_req_valid = !kill && ireq_valid;
            mem_req_addr  = ireq_addr;
            iresp_valid   = mem_resp_valid;
            iresp_inst    = mem_resp_data;
        end
    end

    assign iresp_addr = req_addr;

    always_ff @(posedge clk) begin
        if (rst || kill) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (sv32_en && ireq_valid) begin
                        state <= WALK_REQ;
                    end
                end
                WALK_REQ: begin
                    if (mem_req_valid && mem_req_ready) begin
                        state <= WALK_WAIT;
                    end
                end
                WALK_WAIT: begin
                    if (mem_resp_valid) begin
                        // a leaf, or a level-0 table pointer, ends the walk
                        if (pte_leaf || level == 2'b00) begin
                            state <= FETCH_REQ;
                        end else begin
                            state <= WALK_REQ;
                        end
                    end
                end
                FETCH_REQ: begin
                    if (mem_req_valid && mem_req_ready) begin
                        state <= FETCH_WAIT;
                    end
                end
                FETCH_WAIT: begin
                    if (mem_resp_valid) begin
                        state <= DONE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // walk datapath
    always_ff @(posedge clk) begin
        if (state == IDLE && sv32_en && ireq_valid) begin
            req_addr  <= ireq_addr;
            level     <= 2'b01;
            next_addr <= pte_addr(satp_ppn, ireq_vpn1);
        end else if (state == IDLE && !sv32_en && bare_fire) begin
            // bare mode response carries this address back
            req_addr <= ireq_addr;
        end
        if (state == WALK_WAIT && mem_resp_valid) begin
            if (pte_leaf) begin
                case (level)
                    // megapage: ppn1 joined with vpn0
                    2'b01: next_addr <= phys_addr(
                        {pte_ppn[`SV32_PPN_WIDTH-1:`SV32_VPN_WIDTH], vpn0}, page_offset);
                    2'b00: next_addr <= phys_addr(pte_ppn, page_offset);
                    default: next_addr <= '0;
                endcase
            end else if (level == 2'b00) begin
                // level -1 has no fault here, fetch from address 0
                level     <= level - 2'b01;
                next_addr <= '0;
            end else begin
                level     <= level - 2'b01;
                next_addr <= pte_addr(pte_ppn, vpn0);
            end
        end
        if (state == FETCH_WAIT && mem_resp_valid) begin
            inst_q <= mem_resp_data;
        end
    end

endmodule

//--- logic/inst_mem.sv
// single-port word memory for page tables and code, one-cycle read, preload port for the bench
`timescale 1ns/1ps
`include "sv32_macros.svh"

module inst_mem
    import fetch_pkg::*;
(
    input  logic  clk,
    input  logic  rst,

    input  logic  req_valid,
    output logic  req_ready,
    input  addr_t req_addr,

    output logic  resp_valid,
    output addr_t resp_addr,
    output word_t resp_data,

    // preload, wins over a read in the same cycle
    input  logic  load_en,
    input  addr_t load_addr,
    input  word_t load_data
);

    localparam int DEPTH = 1 << `MEM_INDEX_WIDTH;

    word_t      mem [DEPTH];
    mem_index_t rd_index;
    mem_index_t wr_index;
    logic       req_fire;

    // upper address bits alias onto the array
    assign rd_index = req_addr[`WORD_OFFSET_WIDTH +: `MEM_INDEX_WIDTH];
    assign wr_index = load_addr[`WORD_OFFSET_WIDTH +: `MEM_INDEX_WIDTH];

    // one access in flight at most
    assign req_ready = !resp_valid && !load_en;
    assign req_fire  = req_valid && req_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= req_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[wr_index] <= load_data;
        end
        if (req_fire) begin
            resp_addr <= req_addr;
            resp_data <= mem[rd_index];
        end
    end

endmodule

//--- logic/fetch_mmu_top.sv
// top level of the fetch path: fetch unit, Sv32 walker and instruction memory
`timescale 1ns/1ps

module fetch_mmu_top
    import fetch_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    input  priv_mode_t priv_mode,
    input  word_t      satp,

    input  logic       redirect,
    input  addr_t      redirect_pc,

    input  logic       load_en,
    input  addr_t      load_addr,
    input  word_t      load_data,

    output logic       fetch_valid,
    input  logic       fetch_ready,
    output addr_t      fetch_pc,
    output word_t      fetch_inst
);

    logic  ireq_valid;
    logic  ireq_ready;
    addr_t ireq_addr;
    logic  iresp_valid;
    word_t iresp_inst;

    logic  mem_req_valid;
    logic  mem_req_ready;
    addr_t mem_req_addr;
    logic  mem_resp_valid;
    word_t mem_resp_data;

    fetch_unit fetch_unit_i (
        .clk         (clk),
        .rst         (rst),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .ireq_valid  (ireq_valid),
        .ireq_ready  (ireq_ready),
        .ireq_addr   (ireq_addr),
        .iresp_valid (iresp_valid),
        .iresp_inst  (iresp_inst),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready),
        .fetch_pc    (fetch_pc),
        .fetch_inst  (fetch_inst)
    );

    // a redirect also aborts the walk
    page_table_walker page_table_walker_i (
        .clk            (clk),
        .rst            (rst),
        .kill           (redirect),
        .priv_mode      (priv_mode),
        .satp           (satp),
        .ireq_valid     (ireq_valid),
        .ireq_ready     (ireq_ready),
        .ireq_addr      (ireq_addr),
        .iresp_valid    (iresp_valid),
        .iresp_addr     (),
        .iresp_inst     (iresp_inst),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ready  (mem_req_ready),
        .mem_req_addr   (mem_req_addr),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_data  (mem_resp_data)
    );

    inst_mem inst_mem_i (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (mem_req_valid),
        .req_ready  (mem_req_ready),
        .req_addr   (mem_req_addr),
        .resp_valid (mem_resp_valid),
        .resp_addr  (),
        .resp_data  (mem_resp_data),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_data  (load_data)
    );

endmodule

//--- bench/clock_gen.sv
// testbench clock source, 40 ns period, with a synchronous reset held for the first 3 cycles
`timescale 1ns/1ps

module clock_gen (
    output logic clk,
    output logic rst
);

    localparam int HALF_PERIOD = 20;
    localparam int RESET_CYCLES = 3;

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

    // released on a rising edge, like any other synchronous input
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

//--- bench/ptw_assertions.sv
// concurrent checks on the walker handshakes that the testbench binds into every walker
`timescale 1ns/1ps

module ptw_assertions
    import fetch_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input logic        kill,
    input logic        sv32_en,
    input walk_state_t state,
    input logic        mem_req_valid,
    input logic        mem_req_ready,
    input logic        mem_resp_valid,
    input logic        iresp_valid
);

    // a memory request stays up until the memory takes it
    req_held: assert property (
        @(posedge clk) disable iff (rst || kill)
        mem_req_valid && !mem_req_ready |=> mem_req_valid
    ) else $error("memory request dropped before it was accepted");

    // response to the fetch unit is a single-cycle pulse
    resp_pulse: assert property (
        @(posedge clk) disable iff (rst)
        iresp_valid |=> !iresp_valid
    ) else $error("instruction response held for more than one cycle");

    // an idle walker in Sv32 mode has no memory access left in flight
    idle_quiet: assert property (
        @(posedge clk) disable iff (rst || kill)
        sv32_en && (state == IDLE) |-> !mem_resp_valid
    ) else $error("memory response arrived at an idle walker");

endmodule

//--- bench/fetch_mmu_tb.sv
// table-driven testbench of the fetch path that preloads page tables and code and checks every item
`timescale 1ns/1ps
`include "sv32_macros.svh"

module fetch_mmu_tb
    import fetch_pkg::*;
();

    localparam int NUM_ROWS = 6;
    localparam int MEM_WORDS = 1 << `MEM_INDEX_WIDTH;

    logic       clk;
    logic       rst;
    priv_mode_t priv_mode;
    word_t      satp;
    logic       redirect;
    addr_t      redirect_pc;
    logic       load_en;
    addr_t      load_addr;
    word_t      load_data;
    logic       fetch_valid;
    logic       fetch_ready;
    addr_t      fetch_pc;
    word_t      fetch_inst;

    // shadow of what the memory was loaded with
    word_t      image [MEM_WORDS];
    logic [31:0] lcg_state = 32'h8e90_8868;

    string      row_name [NUM_ROWS];
    priv_mode_t row_priv [NUM_ROWS];
    word_t      row_satp [NUM_ROWS];
    addr_t      row_pc [NUM_ROWS];
    int         row_count [NUM_ROWS];
    logic [7:0] row_ready [NUM_ROWS];
    int         row_mid_at [NUM_ROWS];
    addr_t      row_mid_pc [NUM_ROWS];

    int         error_count = 0;
    int         cycle_count = 0;
    int         cycle_limit = 0;

    clock_gen clock_gen_i (
        .clk (clk),
        .rst (rst)
    );

    fetch_mmu_top fetch_mmu_top_i (
        .clk         (clk),
        .rst         (rst),
        .priv_mode   (priv_mode),
        .satp        (satp),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready),
        .fetch_pc    (fetch_pc),
        .fetch_inst  (fetch_inst)
    );

    bind page_table_walker ptw_assertions ptw_assertions_i (
        .clk            (clk),
        .rst            (rst),
        .kill           (kill),
        .sv32_en        (sv32_en),
        .state          (state),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ready  (mem_req_ready),
        .mem_resp_valid (mem_resp_valid),
        .iresp_valid    (iresp_valid)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // reference two-level Sv32 walk over the shadow image
    function automatic addr_t expected_pa(priv_mode_t priv, word_t satp_v, addr_t va);
        logic [33:0] a;
        word_t pte;
        if (priv == M_MODE || !satp_v[31]) begin
            return va;
        end
        a = {satp_v[21:0], 12'b0} + {22'b0, va[31:22], 2'b0};
        pte = image[a[13:2]];
        if (pte[1] || pte[3]) begin
            // megapage
            a = {pte[31:20], va[21:0]};
            return a[31:0];
        end
        a = {pte[31:10], 12'b0} + {22'b0, va[21:12], 2'b0};
        pte = image[a[13:2]];
        if (pte[1] || pte[3]) begin
            a = {pte[31:10], va[11:0]};
            return a[31:0];
        end
        // no leaf by level 0
        return '0;
    endfunction

    task automatic check_value(string name, string what, logic [31:0] exp, logic [31:0] act);
        if (exp !== act) begin
            error_count = error_count + 1;
            $display("** Error: %s %s expected %h actual %h", name, what, exp, act);
            $display("Verification failed");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic set_row(int r, string name, priv_mode_t priv, word_t sv, addr_t pc,
                           int count, logic [7:0] ready, int mid_at, addr_t mid_pc);
        row_name[r]   = name;
        row_priv[r]   = priv;
        row_satp[r]   = sv;
        row_pc[r]     = pc;
        row_count[r]  = count;
        row_ready[r]  = ready;
        row_mid_at[r] = mid_at;
        row_mid_pc[r] = mid_pc;
    endtask

    task automatic build_image();
        for (int i = 0; i < MEM_WORDS; i++) begin
            image[i] = lcg_next() ^ (i * 32'h9e37_79b9);
        end
        // root table at ppn 1
        image[12'h401] = (32'd2 << 10) | 32'h1;
        image[12'h402] = (32'h400 << 10) | 32'hb;
        image[12'h403] = (32'd2 << 10) | 32'h1;
        // level-0 table at ppn 2 whose last entry points back at itself
        image[12'h800] = (32'd3 << 10) | 32'hb;
        image[12'h801] = (32'd4 << 10) | 32'hb;
        image[12'h802] = (32'd2 << 10) | 32'h1;
    endtask

    task automatic preload();
        for (int i = 0; i < MEM_WORDS; i++) begin
            @(posedge clk);
            load_en   <= 1'b1;
            load_addr <= addr_t'(i * 4);
            load_data <= image[i];
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    task automatic run_row(int r);
        addr_t exp_pc;
        addr_t pa;
        int got;
        int step;
        logic fire_redirect;
        logic mid_done;
        logic [2:0] bit_sel;
        exp_pc = row_pc[r];
        got = 0;
        step = 0;
        fire_redirect = 1'b0;
        mid_done = 1'b0;
        @(posedge clk);
        priv_mode   <= row_priv[r];
        satp        <= row_satp[r];
        redirect    <= 1'b1;
        redirect_pc <= row_pc[r];
        fetch_ready <= 1'b0;
        while (got < row_count[r]) begin
            @(posedge clk);
            redirect <= fire_redirect;
            if (fire_redirect) begin
                redirect_pc <= row_mid_pc[r];
                exp_pc = row_mid_pc[r];
                mid_done = 1'b1;
            end
            fire_redirect = 1'b0;
            bit_sel = 3'(step);
            fetch_ready <= row_ready[r][bit_sel];
            step = step + 1;
            // an item seen here leaves at the next rising edge
            @(negedge clk);
            if (fetch_valid && fetch_ready) begin
                pa = expected_pa(row_priv[r], row_satp[r], exp_pc);
                check_value(row_name[r], "pc", exp_pc, fetch_pc);
                check_value(row_name[r], "inst", image[pa[13:2]], fetch_inst);
                exp_pc = exp_pc + addr_t'(4);
                got = got + 1;
            end
            if (!mid_done && row_mid_at[r] != 0 && got >= row_mid_at[r] &&
                fetch_mmu_top_i.page_table_walker_i.state == WALK_WAIT) begin
                fire_redirect = 1'b1;
            end
        end
        // the mid-walk redirect must really have been issued
        if (row_mid_at[r] != 0) begin
            check_value(row_name[r], "redirect issued", 32'd1, 32'(mid_done));
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("run did not finish within %0d cycles", cycle_limit);
            $display("Verification failed");
            $fatal(1, "timeout");
        end
    end

    initial begin
        priv_mode   = M_MODE;
        satp        = '0;
        redirect    = 1'b1;
        redirect_pc = `RESET_PC;
        load_en     = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        fetch_ready = 1'b0;

        set_row(0, "bare_m_mode", M_MODE, 32'h8000_0001, 32'h0000_3000, 6, 8'hff, 0, '0);
        set_row(1, "bare_s_mode", S_MODE, 32'h0000_0001, 32'h0000_2ff8, 4, 8'hdb, 0, '0);
        set_row(2, "sv32_4k_cross", S_MODE, 32'h8000_0001, 32'h0040_0ff0, 8, 8'hff, 0, '0);
        set_row(3, "sv32_megapage", U_MODE, 32'h8000_0001, 32'h0080_3010, 4, 8'hff, 0, '0);
        set_row(4, "sv32_level_m1", S_MODE, 32'h8000_0001, 32'h00c0_2000, 4, 8'hff, 0, '0);
        set_row(5, "sv32_redirect", S_MODE, 32'h8000_0001, 32'h0040_0000, 10, 8'ha6,
                3, 32'h0080_3000);

        cycle_limit = MEM_WORDS + 64;
        for (int r = 0; r < NUM_ROWS; r++) begin
            cycle_limit = cycle_limit + row_count[r] * 16 + 32;
        end

        build_image();
        // redirect stays high so nothing is fetched during the load
        @(posedge clk);
        while (rst) begin
            @(posedge clk);
        end
        preload();

        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end

        if (error_count == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("Verification failed");
            $fatal(1, "checks failed");
        end
    end

endmodule

//--- verilog.f
+incdir+include
logic/fetch_pkg.sv
logic/fetch_unit.sv
logic/page_table_walker.sv
logic/inst_mem.sv
logic/fetch_mmu_top.sv
bench/clock_gen.sv
bench/ptw_assertions.sv
bench/fetch_mmu_tb.sv

//--- Makefile
# Verilator build and run of the fetch path testbench

TOP = fetch_mmu_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir
